// ==== vlog.f ====
+incdir+design
design/pe_pkg.sv
design/pixel_skew.sv
design/mac_column.sv
design/out_shifter.sv
design/pe_array.sv
tb/pe_checker.sv
tb/tb_pe_array.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = tb_pe_array
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/pe_input.txt ====
# T name mode (mode 1 = random m_ready) | B valid_mask last_mask pix0..pix3 wgt0..wgt3
# E row0..row3 last, words in output order, all B/E fields hex
T reset 0
T single 0
B 0 0 01 02 03 04 00 00 00 00
B 0 0 05 06 07 08 00 00 00 00
B 0 0 09 0a 0b 0c 00 00 00 00
B f f 0d 0e 0f 10 02 03 04 05
E 000005 00000a 00000f 000014 0
E 000014 000018 00001c 000020 0
E 00001b 00001e 000021 000024 0
E 00001a 00001c 00001e 000020 1
T accum 0
B 0 0 10 20 30 40 00 00 00 00
B 0 0 01 02 03 04 00 00 00 00
B 1 0 05 06 07 08 03 00 00 00
B f 0 02 04 06 08 02 03 04 05
B f f 03 03 03 03 01 02 05 04
E 000054 0000a8 0000fc 000150 0
E 00001d 000026 00002f 000038 0
E 000013 00001a 000021 000028 0
E 000016 00001d 000024 00002b 1
T signed 0
B 0 0 80 7f 80 ff 00 00 00 00
B 0 0 80 80 01 7f 00 00 00 00
B 0 0 7f 80 ff 00 00 00 00 00
B f f 80 80 7f ff 80 7f 80 ff
E 000080 ffff81 000080 000001 0
E 004000 004000 ffff80 ffc080 0
E 003f01 ffc080 ffff81 000000 0
E 004000 004000 ffc080 000080 1
T random 1
B 0 0 01 02 03 04 00 00 00 00
B 0 0 11 12 13 14 00 00 00 00
B 0 0 21 22 23 24 00 00 00 00
B f f 31 32 33 34 01 02 03 04
B f f f0 f1 f2 f3 ff 02 fe 01
E 000004 000008 00000c 000010 0
E 000033 000036 000039 00003c 0
E 000042 000044 000046 000048 0
E 000031 000032 000033 000034 1
E 000011 000012 000013 000014 0
E ffffbe ffffbc ffffba ffffb8 0
E 000062 000064 000066 000068 0
E 000010 00000f 00000e 00000d 1
T b2b 0
B 0 0 01 11 21 31 00 00 00 00
B 0 0 02 12 22 32 00 00 00 00
B 0 0 03 13 23 33 00 00 00 00
B f f 04 14 24 34 01 01 01 01
B f f 05 15 25 35 02 02 02 02
E 000001 000011 000021 000031 0
E 000002 000012 000022 000032 0
E 000003 000013 000023 000033 0
E 000004 000014 000024 000034 1
E 000004 000024 000044 000064 0
E 000006 000026 000046 000066 0
E 000008 000028 000048 000068 0
E 00000a 00002a 00004a 00006a 1

// ==== tb/tb_pe_array.sv ====
`include "pe_defs.svh"

module tb_pe_array
  import pe_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef weight_t [`PE_COLS-1:0] weight_vec_t;

  // watchdog budget per beat or expected word
  localparam int CYCLES_PER_ITEM = 40;
  localparam int EXTRA_CYCLES    = 500;

  logic                clk;
  logic                resetn;
  logic [`PE_COLS-1:0] s_valid;
  logic [`PE_COLS-1:0] s_cin_last;
  pixel_vec_t          s_pixels;
  weight_vec_t         s_weights;
  logic                s_pix_valid;
  logic                s_ready;
  logic                m_ready;
  logic                m_valid;
  logic                m_last;
  psum_vec_t           m_data;

  // tests, beats and expected words from the input file
  string               test_name [$];
  int                  test_mode [$];
  int                  beat_test [$];
  logic [`PE_COLS-1:0] beat_valid [$];
  logic [`PE_COLS-1:0] beat_last [$];
  pixel_vec_t          beat_pix [$];
  weight_vec_t         beat_wgt [$];
  int                  exp_test [$];
  psum_vec_t           exp_data [$];
  logic                exp_last [$];

  int   seed = 32'hd044671e;
  int   rnd;
  logic rand_mode;
  logic parse_bad;
  int   limit_cycles;

  pe_array pe_array_inst (
    .clk         (clk),
    .resetn      (resetn),
    .s_valid     (s_valid),
    .s_cin_last  (s_cin_last),
    .s_pixels    (s_pixels),
    .s_weights   (s_weights),
    .s_pix_valid (s_pix_valid),
    .s_ready     (s_ready),
    .m_ready     (m_ready),
    .m_valid     (m_valid),
    .m_last      (m_last),
    .m_data      (m_data)
  );

  pe_checker pe_checker_inst (
    .clk     (clk),
    .resetn  (resetn),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_data  (m_data)
  );

  always #10 clk = ~clk;

  // output back-pressure
  // random holes only in marked tests
  always @(posedge clk) begin
    #1;
    if (rand_mode) begin
      rnd = $random(seed);
      m_ready = rnd[0];
    end else begin
      m_ready = 1'b1;
    end
  end

  task automatic load_file();
    int          fd;
    int          n;
    byte         kind;
    string       line;
    string       name;
    int          mode;
    logic [7:0]  b [10];
    logic [23:0] e [4];
    logic [7:0]  el;
    pixel_vec_t  pv;
    weight_vec_t wv;
    psum_vec_t   ev;
    fd = $fopen("tb/pe_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/pe_input.txt");
      parse_bad = 1'b1;
      return;
    end
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": void'($fgets(line, fd));
        "T": begin
          n = $fscanf(fd, "%s %d", name, mode);
          if (n != 2) parse_bad = 1'b1;
          test_name.push_back(name);
          test_mode.push_back(mode);
        end
        "B": begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                      b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7], b[8], b[9]);
          if (n != 10 || test_name.size() == 0) parse_bad = 1'b1;
          for (int r = 0; r < `PE_ROWS; r++) pv[r] = b[2+r];
          for (int c = 0; c < `PE_COLS; c++) wv[c] = b[6+c];
          beat_test.push_back(test_name.size() - 1);
          beat_valid.push_back(b[0][`PE_COLS-1:0]);
          beat_last.push_back(b[1][`PE_COLS-1:0]);
          beat_pix.push_back(pv);
          beat_wgt.push_back(wv);
        end
        "E": begin
          n = $fscanf(fd, "%h %h %h %h %h", e[0], e[1], e[2], e[3], el);
          if (n != 5 || test_name.size() == 0) parse_bad = 1'b1;
          for (int r = 0; r < `PE_ROWS; r++) ev[r] = e[r];
          exp_test.push_back(test_name.size() - 1);
          exp_data.push_back(ev);
          exp_last.push_back(el[0]);
        end
        default: begin
          $display("unknown line kind '%c' in tb/pe_input.txt", kind);
          parse_bad = 1'b1;
        end
      endcase
    end
    $fclose(fd);
  endtask

  // two beats in a row that close every column need more slots than the shifter has
  function automatic logic has_back_to_back_waves(input int t);
    logic found;
    found = 1'b0;
    for (int i = 1; i < beat_test.size(); i++) begin
      if (beat_test[i] == t && beat_test[i-1] == t &&
          &(beat_valid[i] & beat_last[i]) && &(beat_valid[i-1] & beat_last[i-1])) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // hold a beat until the array accepts it
  task automatic drive_beat(input int i);
    s_valid     = beat_valid[i];
    s_cin_last  = beat_last[i];
    s_pixels    = beat_pix[i];
    s_weights   = beat_wgt[i];
    s_pix_valid = 1'b1;
    while (!s_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  // empty beat with nothing valid
  task automatic drive_idle();
    s_valid     = '0;
    s_cin_last  = '0;
    s_pixels    = '0;
    s_weights   = '0;
    s_pix_valid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  initial begin
    clk          = 1'b0;
    resetn       = 1'b0;
    s_valid      = '0;
    s_cin_last   = '0;
    s_pixels     = '0;
    s_weights    = '0;
    s_pix_valid  = 1'b0;
    m_ready      = 1'b1;
    rand_mode    = 1'b0;
    parse_bad    = 1'b0;
    limit_cycles = 0;
    load_file();
    if (parse_bad) begin
      $display("stimulus file could not be read");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      limit_cycles = (beat_test.size() + exp_test.size()) * CYCLES_PER_ITEM + EXTRA_CYCLES;
      repeat (8) @(posedge clk);
      #1 resetn = 1'b1;
      for (int t = 0; t < test_name.size(); t++) begin
        pe_checker_inst.start_test(test_name[t], has_back_to_back_waves(t));
        for (int i = 0; i < exp_test.size(); i++) begin
          if (exp_test[i] == t) pe_checker_inst.push_expected(exp_data[i], exp_last[i]);
        end
        rand_mode = (test_mode[t] != 0);
        for (int i = 0; i < beat_test.size(); i++) begin
          if (beat_test[i] == t) drive_beat(i);
        end
        // flush the array with empty beats until every word is out
        while (pe_checker_inst.pending_count() != 0) drive_idle();
        rand_mode = 1'b0;
        pe_checker_inst.end_test();
      end
      pe_checker_inst.report();
      if (pe_checker_inst.error_count == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

  // budget scales with the file length
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout after %0d cycles, expected words still missing", limit_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== tb/pe_checker.sv ====
`include "pe_defs.svh"

module pe_checker
  import pe_pkg::*;
(
  input logic      clk,
  input logic      resetn,
  input logic      s_ready,
  input logic      m_valid,
  input logic      m_ready,
  input logic      m_last,
  input psum_vec_t m_data
);
  timeunit 1ns;
  timeprecision 100ps;

  // expected words in output order
  psum_vec_t exp_data_q [$];
  logic      exp_last_q [$];

  string     cur_name;
  int        test_count = 0;
  int        word_count = 0;
  int        error_count = 0;
  int        test_words = 0;
  int        test_errors = 0;

  // stall tracking for the hold check
  logic      hold_seen = 1'b0;
  psum_vec_t held_data;
  psum_vec_t exp_word;
  logic      exp_flag;

  // input stall seen during the current test
  logic      want_stall = 1'b0;
  logic      stall_seen = 1'b0;

  function automatic void count_error();
    error_count++;
    test_errors++;
  endfunction

  // the array must be idle between tests and after reset
  task automatic start_test(input string name, input logic stall_wanted);
    cur_name    = name;
    test_words  = 0;
    test_errors = 0;
    want_stall  = stall_wanted;
    stall_seen  = 1'b0;
    if (m_valid !== 1'b0) begin
      $display("FAIL m_valid: got %h expected 0", m_valid);
      count_error();
    end
    if (s_ready !== 1'b1) begin
      $display("FAIL s_ready: got %h expected 1", s_ready);
      count_error();
    end
  endtask

  task automatic push_expected(input psum_vec_t data, input logic last);
    exp_data_q.push_back(data);
    exp_last_q.push_back(last);
  endtask

  function automatic int pending_count();
    return exp_data_q.size();
  endfunction

  task automatic end_test();
    // a full wave that finds every slot taken must stop the input side
    if (want_stall && !stall_seen) begin
      $display("s_ready never fell although full waves closed back to back");
      count_error();
    end
    test_count++;
    $display("test %0d %s: %0d words, %0d errors", test_count, cur_name, test_words,
             test_errors);
  endtask

  task automatic report();
    $display("tests %0d, words %0d, errors %0d", test_count, word_count, error_count);
  endtask

  // sample mid-cycle
  // a word moves on the next rising edge
  always @(negedge clk) begin
    if (resetn) begin
      if (!s_ready) begin
        stall_seen = 1'b1;
      end
      // a stalled head must neither change nor vanish
      if (hold_seen && !m_valid) begin
        $display("output word disappeared while m_ready was low");
        count_error();
      end
      if (hold_seen && (m_data !== held_data)) begin
        $display("FAIL m_data: got %h expected %h while stalled", m_data, held_data);
        count_error();
      end
      if (m_valid && m_ready) begin
        if (exp_data_q.size() == 0) begin
          $display("output word %h arrived with no expected word left", m_data);
          count_error();
        end else begin
          exp_word = exp_data_q.pop_front();
          exp_flag = exp_last_q.pop_front();
          if (m_data !== exp_word) begin
            $display("FAIL m_data: got %h expected %h", m_data, exp_word);
            count_error();
          end
          if (m_last !== exp_flag) begin
            $display("FAIL m_last: got %h expected %h", m_last, exp_flag);
            count_error();
          end
          word_count++;
          test_words++;
        end
      end
      hold_seen = m_valid && !m_ready;
      held_data = m_data;
    end
  end

endmodule

// ==== design/pe_array.sv ====
`include "pe_defs.svh"

module pe_array
  import pe_pkg::*;
(
  input  logic                          clk,
  input  logic                          resetn,
  input  logic      [`PE_COLS-1:0]      s_valid,
  input  logic      [`PE_COLS-1:0]      s_cin_last,
  input  pixel_vec_t                    s_pixels,
  input  weight_t   [`PE_COLS-1:0]      s_weights,
  input  logic                          s_pix_valid,
  output logic                          s_ready,
  input  logic                          m_ready,
  output logic                          m_valid,
  output logic                          m_last,
  output psum_vec_t                     m_data
);

  // one enable for the whole array
  logic array_en;

  // skewed pixels per column
  pixel_vec_t [`PE_COLS-1:0] col_pixels;
  logic       [`PE_COLS-1:0] col_pix_valid;

  // column results and the shifter handshake
  psum_vec_t  [`PE_COLS-1:0] acc_data;
  logic       [`PE_COLS-1:0] acc_done;
  logic       [`PE_COLS-1:0] take;

  // a beat is accepted whenever the array runs
  assign s_ready = array_en;

  pixel_skew pixel_skew_inst (
    .clk           (clk),
    .resetn        (resetn),
    .en            (array_en),
    .s_pixels      (s_pixels),
    .s_pix_valid   (s_pix_valid),
    .s_ready       (s_ready),
    .col_pixels    (col_pixels),
    .col_pix_valid (col_pix_valid)
  );

  // column valid needs both the weight side flag and a real pixel
  for (genvar c = 0; c < `PE_COLS; c++) begin : g_col
    mac_column mac_column_inst (
      .clk         (clk),
      .resetn      (resetn),
      .en          (array_en),
      .valid_in    (s_valid[c] && col_pix_valid[c]),
      .cin_last_in (s_cin_last[c]),
      .pixels      (col_pixels[c]),
      .weight      (s_weights[c]),
      .take        (take[c]),
      .acc_data    (acc_data[c]),
      .acc_done    (acc_done[c])
    );
  end

  out_shifter out_shifter_inst (
    .clk      (clk),
    .resetn   (resetn),
    .acc_data (acc_data),
    .acc_done (acc_done),
    .m_ready  (m_ready),
    .take     (take),
    .array_en (array_en),
    .m_data   (m_data),
    .m_valid  (m_valid),
    .m_last   (m_last)
  );

endmodule

// ==== design/out_shifter.sv ====
`include "pe_defs.svh"

module out_shifter
  import pe_pkg::*;
(
  input  logic                          clk,
  input  logic                          resetn,
  input  psum_vec_t [`PE_COLS-1:0]      acc_data,
  input  logic      [`PE_COLS-1:0]      acc_done,
  input  logic                          m_ready,
  output logic      [`PE_COLS-1:0]      take,
  output logic                          array_en,
  output psum_vec_t                     m_data,
  output logic                          m_valid,
  output logic                          m_last
);

  // slot H is the head and feeds the output port
  localparam int H = `PE_COLS - 1;

  psum_vec_t   slot_data  [`PE_COLS];
  logic        slot_last  [`PE_COLS];
  slot_state_e slot_state [`PE_COLS];

  logic [`PE_COLS-1:0] free;
  logic [`PE_COLS-1:0] load_ok;
  logic [`PE_COLS-1:0] blocked;
  logic [`PE_COLS-1:0] load;
  logic [`PE_COLS-1:0] shift_in;
  logic [`PE_COLS-1:0] move_out;
  logic                head_move;

  assign m_valid   = (slot_state[H] == SLOT_FULL);
  assign m_data    = slot_data[H];
  assign m_last    = slot_last[H];
  assign head_move = m_valid && m_ready;

  for (genvar c = 0; c < `PE_COLS; c++) begin : g_slot
    // this slot and the next must be free
    // every slot to the left must be free too, so older words stay ahead
    localparam int TOP = (c == H) ? c : c + 1;

    slot_state_e left_state;
    psum_vec_t   left_data;
    logic        left_last;

    assign free[c]    = (slot_state[c] == SLOT_FREE);
    assign load_ok[c] = &free[TOP:0];
    assign blocked[c] = acc_done[c] && !load_ok[c];

    // a wave loads as a whole, a blocked higher column holds the lower ones back
    if (c == H) begin : g_head
      assign load[c]     = acc_done[c] && load_ok[c];
      assign move_out[c] = head_move;
    end else begin : g_body
      assign load[c]     = acc_done[c] && load_ok[c] && !(|blocked[H:c+1]);
      assign move_out[c] = shift_in[c+1];
    end

    // nothing enters slot 0 from the left
    if (c == 0) begin : g_first
      assign left_state = SLOT_FREE;
      assign left_data  = slot_data[c];
      assign left_last  = 1'b0;
    end else begin : g_next
      assign left_state = slot_state[c-1];
      assign left_data  = slot_data[c-1];
      assign left_last  = slot_last[c-1];
    end

    // pull from the left when empty or when the own word moves on
    assign shift_in[c] = !load[c] && (free[c] || move_out[c]);

    always_ff @(posedge clk) begin
      if (!resetn) begin
        slot_state[c] <= SLOT_FREE;
      end else if (load[c]) begin
        slot_state[c] <= SLOT_FULL;
      end else if (shift_in[c]) begin
        slot_state[c] <= left_state;
      end else if (move_out[c]) begin
        slot_state[c] <= SLOT_FREE;
      end
    end

    // column 0 closes the wave
    always_ff @(posedge clk) begin
      if (load[c]) begin
        slot_data[c] <= acc_data[c];
        slot_last[c] <= (c == 0);
      end else if (shift_in[c]) begin
        slot_data[c] <= left_data;
        slot_last[c] <= left_last;
      end
    end
  end

  assign take = load;

  // freeze everything while any finished sum has nowhere to go
  assign array_en = !(|(acc_done & ~load));

  a_head_hold: assert property (@(posedge clk) disable iff (!resetn)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data)))
    else $error("m_data changed while the output was stalled");

endmodule

// ==== design/mac_column.sv ====
`include "pe_defs.svh"

module mac_column
  import pe_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic       en,
  input  logic       valid_in,
  input  logic       cin_last_in,
  input  pixel_vec_t pixels,
  input  weight_t    weight,
  input  logic       take,
  output psum_vec_t  acc_data,
  output logic       acc_done
);

  localparam int DLY = `PE_MUL_DELAY;

  // operand stage
  pixel_vec_t pix_q;
  weight_t    wgt_q;

  // control delay line, bit DLY-1 lines up with the product
  logic [DLY-1:0] vld_dl;
  logic [DLY-1:0] last_dl;
  logic           mul_valid;
  logic           mul_last;

  // multiplier and its extra pipeline stages
  prod_t prod_comb [`PE_ROWS];
  prod_t prod_pipe [DLY-1][`PE_ROWS];

  // accumulator control
  psum_t      acc_next [`PE_ROWS];
  logic       bypass_sum;
  logic       acc_en;
  logic       close;
  acc_state_e acc_state;

  // weight and pixels are captured together on an accepted beat
  always_ff @(posedge clk) begin
    if (en) begin
      pix_q <= pixels;
      wgt_q <= weight;
    end
  end

  // valid and last travel beside the multiplier pipe
  always_ff @(posedge clk) begin
    if (!resetn) begin
      vld_dl  <= '0;
      last_dl <= '0;
    end else if (en) begin
      vld_dl  <= (vld_dl << 1) | DLY'(valid_in);
      last_dl <= (last_dl << 1) | DLY'(cin_last_in);
    end
  end

  assign mul_valid = vld_dl[DLY-1];
  assign mul_last  = last_dl[DLY-1];

  // one signed multiplier per row
  always_comb begin
    for (int r = 0; r < `PE_ROWS; r++) begin
      prod_comb[r] = $signed(pix_q[r]) * $signed(wgt_q);
    end
  end

  // several beats can be in flight here
  always_ff @(posedge clk) begin
    if (en) begin
      prod_pipe[0] <= prod_comb;
      for (int s = 1; s < DLY - 1; s++) begin
        prod_pipe[s] <= prod_pipe[s-1];
      end
    end
  end

  assign acc_en = en && mul_valid;
  assign close  = acc_en && mul_last;

  // first product of a group replaces the old sum instead of adding to it
  always_comb begin
    for (int r = 0; r < `PE_ROWS; r++) begin
      acc_next[r] = (bypass_sum ? psum_t'(0) : acc_data[r]) + psum_t'(prod_pipe[DLY-2][r]);
    end
  end

  always_ff @(posedge clk) begin
    if (acc_en) begin
      for (int r = 0; r < `PE_ROWS; r++) begin
        acc_data[r] <= acc_next[r];
      end
    end
  end

  // a closing product arms the bypass for the next group
  always_ff @(posedge clk) begin
    if (!resetn) begin
      bypass_sum <= 1'b1;
    end else if (acc_en) begin
      bypass_sum <= mul_last;
    end
  end

  // take can arrive while the array is frozen
  // a new closing product wins over take, the fresh sum is done again
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc_state <= ACC_RUN;
    end else if (close) begin
      acc_state <= ACC_DONE;
    end else if (take) begin
      acc_state <= ACC_RUN;
    end
  end

  assign acc_done = (acc_state == ACC_DONE);

  // the shifter must empty a done column before the next product lands
  a_no_overrun: assert property (@(posedge clk) disable iff (!resetn)
    (acc_en && acc_state == ACC_DONE) |-> take)
    else $error("product reached a done accumulator that was not taken");

endmodule

// ==== design/pixel_skew.sv ====
`include "pe_defs.svh"

module pixel_skew
  import pe_pkg::*;
(
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           en,
  input  pixel_vec_t                     s_pixels,
  input  logic                           s_pix_valid,
  input  logic                           s_ready,
  output pixel_vec_t [`PE_COLS-1:0]      col_pixels,
  output logic       [`PE_COLS-1:0]      col_pix_valid
);

  // stage c holds the vector accepted c beats ago
  // column 0 works on the incoming beat directly, so stage 0 has no register
  pixel_vec_t skew_q [1:`PE_COLS-1];
  logic       valid_q [1:`PE_COLS-1];

  assign col_pixels[0]    = s_pixels;
  assign col_pix_valid[0] = s_pix_valid;

  for (genvar c = 1; c < `PE_COLS; c++) begin : g_stage

    // pixel chain, zero until the first beat has walked this far
    always_ff @(posedge clk) begin
      if (!resetn) begin
        skew_q[c] <= '0;
      end else if (en) begin
        skew_q[c] <= col_pixels[c-1];
      end
    end

    // valid follows the vector one column per enabled cycle
    // a vector that this column consumed without a successor is dropped
    always_ff @(posedge clk) begin
      if (!resetn) begin
        valid_q[c] <= 1'b0;
      end else if (en) begin
        valid_q[c] <= col_pix_valid[c-1];
      end else if (s_ready) begin
        valid_q[c] <= 1'b0;
      end
    end

    assign col_pixels[c]    = skew_q[c];
    assign col_pix_valid[c] = valid_q[c];

  end

endmodule

// ==== design/pe_pkg.sv ====
`include "pe_defs.svh"

package pe_pkg;

  // scalar data types, all signed
  typedef logic signed [`PE_X_BITS-1:0] pixel_t;
  typedef logic signed [`PE_K_BITS-1:0] weight_t;
  typedef logic signed [`PE_X_BITS+`PE_K_BITS-1:0] prod_t;
  typedef logic signed [`PE_Y_BITS-1:0] psum_t;

  // one value per row
  typedef pixel_t [`PE_ROWS-1:0] pixel_vec_t;
  typedef psum_t [`PE_ROWS-1:0] psum_vec_t;

  // output shifter slot occupancy
  typedef enum logic {
    SLOT_FREE,
    SLOT_FULL
  } slot_state_e;

  // column accumulator state
  // done means a finished sum waits for its output slot
  typedef enum logic {
    ACC_RUN,
    ACC_DONE
  } acc_state_e;

endpackage

// ==== design/pe_defs.svh ====
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

// array geometry
// rows carry one pixel lane each, columns one weight each
`define PE_ROWS 4
`define PE_COLS 4

// operand widths, both operands are two's complement
`define PE_X_BITS 8
`define PE_K_BITS 8

// accumulator width
// wide enough for many full-scale products of one group
`define PE_Y_BITS 24

// register stages from operand capture to the product
// the operand register counts as the first stage, so at least 2
`define PE_MUL_DELAY 3

`endif
